// ==== verilog/areg_types_pkg.sv ====
package areg_types_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int ADDR_W = 32;     // Address and register width
    localparam int EXT_W  = 16;     // Extension word width
    localparam int TAG_W  = 4;

    // ------------------------------
    // Plain types
    // ------------------------------
    typedef logic [ADDR_W-1:0] addr_t;      // Address or register value
    typedef logic [2:0]        areg_idx_t;  // A0..A6 plus 7 for the active SP
    typedef logic [EXT_W-1:0]  ext_word_t;  // Raw extension word
    typedef logic [1:0]        op_size_t;   // Operand size code
    typedef logic [TAG_W-1:0]  tag_t;       // Echoed back with the result

    // Operand size codes
    localparam op_size_t SIZE_BYTE = 2'd0;
    localparam op_size_t SIZE_WORD = 2'd1;
    localparam op_size_t SIZE_LONG = 2'd2;

    // Register 7 is the banked stack pointer
    localparam areg_idx_t SP_IDX = 3'd7;

endpackage

// ==== verilog/ea_cmd_pkg.sv ====
package ea_cmd_pkg;

    // ------------------------------
    // Addressing modes
    // ------------------------------
    typedef enum logic [2:0] {
        mode_ind   = 3'd0,  // (An)
        mode_post  = 3'd1,  // (An)+
        mode_pre   = 3'd2,  // -(An)
        mode_disp  = 3'd3,  // (d16,An)
        mode_idx   = 3'd4,  // (d8,An,Xn) brief format
        mode_abs_w = 3'd5,  // (xxx).W
        mode_abs_l = 3'd6   // (xxx).L
    } ea_mode_e;

    // Command as issued by the caller
    typedef struct packed {
        ea_mode_e                  mode;
        areg_types_pkg::areg_idx_t areg;        // Base register
        areg_types_pkg::op_size_t  size;
        areg_types_pkg::tag_t      tag;
        areg_types_pkg::ext_word_t ext0;        // d16, brief word or abs high
        areg_types_pkg::ext_word_t ext1;        // Abs long low word
        areg_types_pkg::addr_t     index_data;  // Dn value when Xn is a data reg
    } ea_cmd_t;

    // Command after extension-word decode
    typedef struct packed {
        ea_mode_e                  mode;
        areg_types_pkg::areg_idx_t base;
        areg_types_pkg::op_size_t  size;
        areg_types_pkg::tag_t      tag;
        areg_types_pkg::addr_t     disp;        // Sign extended disp or abs address
        logic                      idx_is_areg; // Xn is An
        areg_types_pkg::areg_idx_t idx_reg;
        logic                      idx_long;    // Xn.L, else Xn.W
        logic [1:0]                scale;       // Shift count 0..3
        areg_types_pkg::addr_t     index_data;
    } ea_dec_t;

    // Register write or update
    typedef struct packed {
        logic                      en;
        areg_types_pkg::areg_idx_t idx;
        areg_types_pkg::addr_t     data;
    } areg_wr_t;

    // Result back to the caller
    typedef struct packed {
        areg_types_pkg::tag_t  tag;
        areg_types_pkg::addr_t addr;
    } ea_res_t;

endpackage

// ==== verilog/ea_cmd_capture.sv ====
`timescale 1ns/1ns

module ea_cmd_capture #(
    parameter int ADDR_W = 32
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  ea_cmd_pkg::ea_cmd_t  cmd,
    output logic                 dec_valid,
    output ea_cmd_pkg::ea_dec_t  dec
);

    ea_cmd_pkg::ea_dec_t dec_d;     // Decoded form of the incoming command

    // ------------------------------
    // Extension word decode
    // ------------------------------
    always_comb begin
        dec_d.mode       = cmd.mode;
        dec_d.base       = cmd.areg;
        dec_d.size       = cmd.size;
        dec_d.tag        = cmd.tag;
        dec_d.index_data = cmd.index_data;

        // Brief format holds D/A, reg, W/L, scale and d8
        dec_d.idx_is_areg = cmd.ext0[15];
        dec_d.idx_reg     = cmd.ext0[14:12];
        dec_d.idx_long    = cmd.ext0[11];
        dec_d.scale       = cmd.ext0[10:9];

        case (cmd.mode)
            ea_cmd_pkg::mode_disp,
            ea_cmd_pkg::mode_abs_w:
                dec_d.disp = {{(ADDR_W-16){cmd.ext0[15]}}, cmd.ext0};  // Sign extended word
            ea_cmd_pkg::mode_idx:
                dec_d.disp = {{(ADDR_W-8){cmd.ext0[7]}}, cmd.ext0[7:0]};
            ea_cmd_pkg::mode_abs_l:
                dec_d.disp = {cmd.ext0, cmd.ext1};  // High word first
            default:
                dec_d.disp = '0;                    // No displacement
        endcase
    end

    // ------------------------------
    // Stage register
    // ------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= cmd_valid;     // No ready so always accepted
        end
    end

    // Payload only loads on an accepted command
    always_ff @(posedge CLK) begin
        if (cmd_valid) begin
            dec <= dec_d;
        end
    end

endmodule

// ==== verilog/areg_file.sv ====
`timescale 1ns/1ns

module areg_file #(
    parameter int ADDR_W = 32
) (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       sbit,       // Supervisor
    input  logic                       mbit,       // Master
    input  ea_cmd_pkg::areg_wr_t       wr,         // Caller write port
    input  ea_cmd_pkg::areg_wr_t       upd,        // Post/pre step from calc
    input  areg_types_pkg::areg_idx_t  base_idx,
    output areg_types_pkg::addr_t      base_data,
    input  areg_types_pkg::areg_idx_t  index_idx,
    output areg_types_pkg::addr_t      index_data
);

    // ------------------------------
    // Physical slots
    // ------------------------------
    // A0..A6 in slots 0..6 and then USP, ISP, MSP
    localparam int NUM_SLOTS = 10;
    localparam logic [3:0] USP_SLOT = 4'd7;
    localparam logic [3:0] ISP_SLOT = 4'd8;
    localparam logic [3:0] MSP_SLOT = 4'd9;

    logic [ADDR_W-1:0] regs [NUM_SLOTS];
    logic [3:0]        sp_slot;     // Stack pointer behind register 7
    logic [3:0]        base_slot;
    logic [3:0]        index_slot;
    logic [3:0]        wr_slot;
    logic [3:0]        upd_slot;

    // Map a register number onto its slot
    function automatic logic [3:0] slot_of(
        input areg_types_pkg::areg_idx_t idx,
        input logic [3:0]                sp
    );
        if (idx == areg_types_pkg::SP_IDX) begin
            return sp;
        end
        return {1'b0, idx};
    endfunction

    // ------------------------------
    // Stack pointer banking
    // ------------------------------
    always_comb begin
        if (!sbit) begin
            sp_slot = USP_SLOT;         // User mode
        end else if (mbit) begin
            sp_slot = MSP_SLOT;         // Supervisor and master
        end else begin
            sp_slot = ISP_SLOT;         // Supervisor and interrupt
        end
    end

    assign base_slot  = slot_of(base_idx, sp_slot);
    assign index_slot = slot_of(index_idx, sp_slot);
    assign wr_slot    = slot_of(wr.idx, sp_slot);   // Bank sampled at the write edge
    assign upd_slot   = slot_of(upd.idx, sp_slot);

    // ------------------------------
    // Read ports
    // ------------------------------
    // Plain combinational reads of the state left by the last edge
    assign base_data  = regs[base_slot];
    assign index_data = regs[index_slot];

    // ------------------------------
    // Write and update
    // ------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (upd.en) begin
                regs[upd_slot] <= upd.data;     // Post/pre step
            end
            // Later assignment wins on a slot collision
            if (wr.en) begin
                regs[wr_slot] <= wr.data;       // Always long
            end
        end
    end

endmodule

// ==== verilog/ea_calc.sv ====
`timescale 1ns/1ns

module ea_calc #(
    parameter int ADDR_W = 32
) (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       dec_valid,
    input  ea_cmd_pkg::ea_dec_t        dec,
    output areg_types_pkg::areg_idx_t  base_idx,
    input  areg_types_pkg::addr_t      base_data,
    output areg_types_pkg::areg_idx_t  index_idx,
    input  areg_types_pkg::addr_t      index_data,
    output ea_cmd_pkg::areg_wr_t       upd,
    output logic                       res_in_valid,
    output ea_cmd_pkg::ea_res_t        res_in
);

    logic [ADDR_W-1:0] idx_src;     // Xn before sizing
    logic [ADDR_W-1:0] idx_ext;
    logic [ADDR_W-1:0] idx_scaled;
    logic [ADDR_W-1:0] step;        // Post/pre step
    logic [ADDR_W-1:0] ea;

    assign base_idx  = dec.base;
    assign index_idx = dec.idx_reg;

    // ------------------------------
    // Index path
    // ------------------------------
    assign idx_src    = dec.idx_is_areg ? index_data : dec.index_data;
    assign idx_ext    = dec.idx_long ? idx_src
                                     : {{(ADDR_W-16){idx_src[15]}}, idx_src[15:0]};
    assign idx_scaled = idx_ext << dec.scale;  // x1, x2, x4, x8

    // Byte on SP keeps it word aligned
    always_comb begin
        case (dec.size)
            areg_types_pkg::SIZE_BYTE:
                step = (dec.base == areg_types_pkg::SP_IDX) ? ADDR_W'(2) : ADDR_W'(1);
            areg_types_pkg::SIZE_WORD:
                step = ADDR_W'(2);
            default:
                step = ADDR_W'(4);
        endcase
    end

    // ------------------------------
    // Effective address
    // ------------------------------
    always_comb begin
        case (dec.mode)
            ea_cmd_pkg::mode_pre:   ea = base_data - step;          // New value
            ea_cmd_pkg::mode_disp:  ea = base_data + dec.disp;
            ea_cmd_pkg::mode_idx:   ea = base_data + dec.disp + idx_scaled;
            ea_cmd_pkg::mode_abs_w,
            ea_cmd_pkg::mode_abs_l: ea = dec.disp;                  // Decoded in capture
            default:                ea = base_data;                 // (An) and (An)+
        endcase
    end

    // Update goes to the file this cycle so the next command chains
    always_comb begin
        upd.en   = dec_valid && (dec.mode == ea_cmd_pkg::mode_post ||
                                 dec.mode == ea_cmd_pkg::mode_pre);
        upd.idx  = dec.base;
        upd.data = (dec.mode == ea_cmd_pkg::mode_post) ? base_data + step : ea;
    end

    // ------------------------------
    // Result register
    // ------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            res_in_valid <= 1'b0;
        end else begin
            res_in_valid <= dec_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (dec_valid) begin
            res_in.tag  <= dec.tag;
            res_in.addr <= ea;
        end
    end

endmodule

// ==== verilog/ea_result_queue.sv ====
`timescale 1ns/1ns

module ea_result_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 res_in_valid,
    input  ea_cmd_pkg::ea_res_t  res_in,
    input  logic                 res_credit,    // Consumer returns one
    output logic                 res_valid,
    output ea_cmd_pkg::ea_res_t  res,
    output logic                 cmd_credit     // Back to the caller
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    ea_cmd_pkg::ea_res_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    fill;          // Entries held
    logic [CRD_W-1:0]    out_credits;   // Consumer slots left
    logic                push;
    logic                pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push       = res_in_valid;   // Upstream credits guarantee room
    assign pop        = res_valid;
    assign res_valid  = (fill != '0) && (out_credits != '0);
    assign res        = mem[rd_ptr];
    assign cmd_credit = pop;            // Slot freed as the result leaves

    // ------------------------------
    // Pointers and counters
    // ------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            out_credits <= CRD_W'(OUT_CREDITS);
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;                      // Both or neither
            endcase
            case ({pop, res_credit})
                2'b10:   out_credits <= out_credits - 1'b1;
                2'b01:   out_credits <= out_credits + 1'b1;
                default: ;
            endcase
        end
    end

    // Storage
    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= res_in;
        end
    end

endmodule

// ==== verilog/ea_unit_top.sv ====
`timescale 1ns/1ns

module ea_unit_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2,
    parameter int ADDR_W      = 32
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    input  ea_cmd_pkg::ea_cmd_t   cmd,
    output logic                  cmd_credit,
    input  ea_cmd_pkg::areg_wr_t  wr,
    input  logic                  sbit,
    input  logic                  mbit,
    output logic                  res_valid,
    output ea_cmd_pkg::ea_res_t   res,
    input  logic                  res_credit
);

    // ------------------------------
    // Internal paths
    // ------------------------------
    logic                       dec_valid;
    ea_cmd_pkg::ea_dec_t        dec;
    areg_types_pkg::areg_idx_t  base_idx;
    areg_types_pkg::addr_t      base_data;
    areg_types_pkg::areg_idx_t  index_idx;
    areg_types_pkg::addr_t      index_data;
    ea_cmd_pkg::areg_wr_t       upd;
    logic                       res_in_valid;
    ea_cmd_pkg::ea_res_t        res_in;

    ea_cmd_capture #(.ADDR_W(ADDR_W)) capture_i (
        .CLK, .RESET, .cmd_valid, .cmd, .dec_valid, .dec
    );

    areg_file #(.ADDR_W(ADDR_W)) regs_i (
        .CLK, .RESET, .sbit, .mbit, .wr, .upd,
        .base_idx, .base_data, .index_idx, .index_data
    );

    ea_calc #(.ADDR_W(ADDR_W)) calc_i (
        .CLK, .RESET, .dec_valid, .dec, .base_idx, .base_data,
        .index_idx, .index_data, .upd, .res_in_valid, .res_in
    );

    ea_result_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)) queue_i (
        .CLK, .RESET, .res_in_valid, .res_in, .res_credit,
        .res_valid, .res, .cmd_credit
    );

endmodule

// ==== verification/ea_unit_asserts.sv ====
`timescale 1ns/1ns

module ea_unit_asserts #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input logic CLK,
    input logic RESET,
    input logic cmd_valid,
    input logic cmd_credit,
    input logic res_valid,
    input logic res_credit
);

    int out_used;           // Results sent minus credits back
    int up_credits;         // Credits the caller holds
    int fail_count = 0;     // Summed up at the end of the run

    always @(posedge CLK) begin
        if (RESET) begin
            out_used   <= 0;
            up_credits <= QUEUE_DEPTH;
        end else begin
            out_used   <= out_used + int'(res_valid) - int'(res_credit);
            up_credits <= up_credits - int'(cmd_valid) + int'(cmd_credit);
        end
    end

    // ------------------------------
    // Credit protocol
    // ------------------------------
    out_credit_limit: assert property (@(posedge CLK) disable iff (RESET)
        out_used <= OUT_CREDITS)
        else begin
            $error("more results sent than output credits allow");
            fail_count++;
        end

    cmd_needs_credit: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> up_credits > 0)
        else begin
            $error("command issued with no credit left");
            fail_count++;
        end

    // Outputs quiet right after reset
    quiet_after_reset: assert property (@(posedge CLK) RESET |=> !res_valid && !cmd_credit)
        else begin
            $error("res_valid or cmd_credit high after reset");
            fail_count++;
        end

endmodule

bind ea_unit_top ea_unit_asserts #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
) asserts_i (
    .CLK(CLK),
    .RESET(RESET),
    .cmd_valid(cmd_valid),
    .cmd_credit(cmd_credit),
    .res_valid(res_valid),
    .res_credit(res_credit)
);

// ==== verification/ea_unit_tb.sv ====
`timescale 1ns/1ns

module ea_unit_tb;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int WAIT_LIMIT  = 200;       // Cycles per wait loop

    logic                  CLK;
    logic                  RESET;
    logic                  cmd_valid;
    ea_cmd_pkg::ea_cmd_t   cmd;
    logic                  cmd_credit;
    ea_cmd_pkg::areg_wr_t  wr;
    logic                  sbit;
    logic                  mbit;
    logic                  res_valid;
    ea_cmd_pkg::ea_res_t   res;
    logic                  res_credit;

    areg_types_pkg::addr_t model [10];      // A0..A6, USP, ISP, MSP
    ea_cmd_pkg::ea_res_t   exp_q [$];       // Expected results in tag order
    ea_cmd_pkg::ea_res_t   exp_res;
    ea_cmd_pkg::ea_cmd_t   pend;            // Command now sitting in calc
    logic                  pend_valid;
    logic [3:0]            next_tag;
    integer                seed;
    int errors, sent, credit_pulses, consumed, returned, hold_cycles;

    ea_unit_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS), .ADDR_W(32)) dut_i (.*);

    always #50 CLK = ~CLK;

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic int phys_slot(input logic [2:0] r, input logic s, input logic m);
        if (r != 3'd7) return r;
        return !s ? 7 : (m ? 9 : 8);        // USP in user mode else MSP or ISP
    endfunction

    function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
        return $signed(v << (32 - bits)) >>> (32 - bits);
    endfunction

    // Expected address that also steps the model on (An)+ and -(An)
    function automatic logic [31:0] ref_ea(input ea_cmd_pkg::ea_cmd_t c, input logic s,
                                           input logic m);
        int          b;
        logic [31:0] stp;
        logic [31:0] xn;
        logic [31:0] ea;
        b   = phys_slot(c.areg, s, m);
        stp = (c.size == 2'd0) ? ((c.areg == 3'd7) ? 2 : 1) : ((c.size == 2'd1) ? 2 : 4);
        xn  = c.ext0[15] ? model[phys_slot(c.ext0[14:12], s, m)] : c.index_data;
        xn  = (c.ext0[11] ? xn : sext(xn, 16)) << c.ext0[10:9];
        ea  = model[b];
        case (c.mode)
            ea_cmd_pkg::mode_post:  model[b] = ea + stp;    // Old value out
            ea_cmd_pkg::mode_pre: begin
                ea       = ea - stp;
                model[b] = ea;
            end
            ea_cmd_pkg::mode_disp:  ea = ea + sext(c.ext0, 16);
            ea_cmd_pkg::mode_idx:   ea = ea + sext(c.ext0[7:0], 8) + xn;
            ea_cmd_pkg::mode_abs_w: ea = sext(c.ext0, 16);
            ea_cmd_pkg::mode_abs_l: ea = {c.ext0, c.ext1};
            default: ;                                      // (An)
        endcase
        return ea;
    endfunction

    function automatic ea_cmd_pkg::ea_cmd_t make_cmd(input int mode, input int r, input int sz);
        ea_cmd_pkg::ea_cmd_t c;
        c.mode       = ea_cmd_pkg::ea_mode_e'(mode);
        c.areg       = 3'(r);
        c.size       = 2'(sz);
        c.tag        = next_tag;
        c.ext0       = 16'($random(seed));
        c.ext1       = 16'($random(seed));
        c.index_data = $random(seed);
        next_tag++;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        if (got !== expv) begin
            $display("mismatch at %0t ns: %s got %h, expected %h", $time, name, got, expv);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d, assertion failures: %0d", errors, dut_i.asserts_i.fail_count);
        if (errors == 0 && dut_i.asserts_i.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    // One falling edge after which the model stands at the next rising edge
    task automatic apply_cycle(input logic v, input ea_cmd_pkg::ea_cmd_t c,
                               input ea_cmd_pkg::areg_wr_t w, input logic s, input logic m);
        ea_cmd_pkg::ea_res_t r;
        @(negedge CLK);
        cmd_valid  = v;
        cmd        = c;
        wr         = w;
        sbit       = s;
        mbit       = m;
        res_credit = 1'b0;
        if (hold_cycles > 0) begin
            hold_cycles--;                  // Consumer stalls
        end else if (consumed > returned && ($random(seed) & 3) != 0) begin
            res_credit = 1'b1;
            returned++;
        end
        if (pend_valid) begin
            r.tag  = pend.tag;
            r.addr = ref_ea(pend, s, m);    // Bank seen at the update edge
            exp_q.push_back(r);
        end
        if (w.en) model[phys_slot(w.idx, s, m)] = w.data;     // After the update so write wins
        pend_valid = v;
        pend       = c;
        sent      += v;
    endtask

    task automatic send(input ea_cmd_pkg::ea_cmd_t c, input ea_cmd_pkg::areg_wr_t w,
                        input logic s, input logic m);
        int waited;
        waited = 0;
        while (QUEUE_DEPTH - sent + credit_pulses == 0 && waited < WAIT_LIMIT) begin
            apply_cycle(1'b0, '0, '0, s, m);
            waited++;
        end
        if (waited == WAIT_LIMIT) begin
            $display("timeout: no command credit came back within %0d cycles", WAIT_LIMIT);
            errors++;
            finish_run();
        end else begin
            apply_cycle(1'b1, c, w, s, m);
        end
    endtask

    task automatic drain(input logic s, input logic m);
        int waited;
        waited = 0;
        while ((pend_valid || exp_q.size() != 0 || credit_pulses < sent)
               && waited < WAIT_LIMIT) begin
            apply_cycle(1'b0, '0, '0, s, m);
            waited++;
        end
        if (waited == WAIT_LIMIT) begin
            $display("timeout: results still outstanding after %0d cycles", WAIT_LIMIT);
            errors++;
            finish_run();
        end else begin
            check_value("cmd_credit pulses", credit_pulses, sent);
        end
    endtask

    initial begin
        ea_cmd_pkg::ea_cmd_t c;
        int s, m, r, k;
        seed = 45082;
        {CLK, RESET, cmd_valid, cmd, wr, sbit, mbit, res_credit} = '0;
        RESET = 1'b1;
        {errors, sent, credit_pulses, consumed, returned, hold_cycles} = '0;
        {pend_valid, pend, next_tag} = '0;
        foreach (model[i]) model[i] = '0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        for (r = 0; r < 7; r++) begin       // Write then (An)
            apply_cycle(1'b0, '0, '{1'b1, 3'(r), $random(seed)}, 1'b0, 1'b0);
            send(make_cmd(0, r, 2), '0, 1'b0, 1'b0);
        end
        for (k = 0; k < 3; k++) begin       // One write per SP bank
            apply_cycle(1'b0, '0, '{1'b1, 3'd7, $random(seed)}, k > 0, k == 2);
        end
        for (k = 0; k < 3; k++) begin       // Read back each SP bank
            send(make_cmd(0, 7, 2), '0, k > 0, k == 2);
            apply_cycle(1'b0, '0, '0, k > 0, k == 2);
        end
        for (r = 0; r < 8; r++) begin       // Back to back steps chain
            for (k = 0; k < 12; k++) send(make_cmd(1 + (k / 2) % 2, r, k / 4), '0, 1'b1, 1'b0);
        end
        for (k = 0; k < 128; k++) begin     // Every index form
            c            = make_cmd(4, k % 7, 1);
            c.ext0[15:9] = 7'(k);
            c.ext0[7]    = k[0];            // Negative d8 on odd k
            send(c, '0, 1'b0, 1'b0);
        end
        for (k = 0; k < 32; k++) send(make_cmd(3 + k % 4, k % 8, 2), '0, 1'b0, 1'b0);
        drain(1'b0, 1'b0);
        hold_cycles = 30 + ($random(seed) & 31);
        for (k = 0; k < 12; k++) send(make_cmd(k % 7, k % 8, k % 3), '0, 1'b0, 1'b0);
        drain(1'b0, 1'b0);
        s = 0;
        m = 0;
        for (k = 0; k < 300; k++) begin     // Random mix
            if (($random(seed) & 7) == 0) begin
                s = $random(seed) & 1;
                m = $random(seed) & 1;
            end
            c = make_cmd($unsigned($random(seed)) % 7, $random(seed) & 7,
                         $unsigned($random(seed)) % 3);
            if (($random(seed) & 3) == 0) begin
                send(c, '{1'b1, 3'($random(seed)), $random(seed)}, s, m);
            end else begin
                send(c, '0, s, m);
            end
        end
        drain(s, m);
        finish_run();
    end

    // ------------------------------
    // Compare
    // ------------------------------
    always @(posedge CLK) begin
        if (!RESET) begin
            credit_pulses += cmd_credit;
            if (res_valid) begin
                consumed++;
                if (exp_q.size() == 0) begin
                    $display("error at %0t ns: result tag %h came with no command outstanding",
                             $time, res.tag);
                    errors++;
                end else begin
                    exp_res = exp_q.pop_front();
                    check_value("res.tag", res.tag, exp_res.tag);
                    check_value("res.addr", res.addr, exp_res.addr);
                end
            end
        end
    end

endmodule

// ==== files.f ====
verilog/areg_types_pkg.sv
verilog/ea_cmd_pkg.sv
verilog/ea_cmd_capture.sv
verilog/areg_file.sv
verilog/ea_calc.sv
verilog/ea_result_queue.sv
verilog/ea_unit_top.sv
verification/ea_unit_asserts.sv
verification/ea_unit_tb.sv

// ==== Bender.yml ====
package:
  name: ea_unit

sources:
  - verilog/areg_types_pkg.sv
  - verilog/ea_cmd_pkg.sv
  - verilog/ea_cmd_capture.sv
  - verilog/areg_file.sv
  - verilog/ea_calc.sv
  - verilog/ea_result_queue.sv
  - verilog/ea_unit_top.sv
  - target: test
    files:
      - verification/ea_unit_asserts.sv
      - verification/ea_unit_tb.sv
